/* hw/dmix_pkg.sv */
// audio mixer shared constants
`default_nettype none

package dmix_pkg;

    // pcm sample width, two's complement
    localparam int unsigned SAMPLE_W = 24;

    // slots per input buffer, also the initial credit count
    localparam int unsigned BUF_DEPTH = 8;
    localparam int unsigned BUF_AW = 3;

    // i2s timing in clk491520 cycles
    localparam int unsigned BCK_DIV = 16;
    localparam int unsigned SLOT_BITS = 32;

endpackage

`default_nettype wire

/* hw/sample_buffer.sv */
// credit-based input sample buffer
`timescale 1ns/1ns
`default_nettype none

module sample_buffer
    import dmix_pkg::*;
(
    input  wire                  clk491520,
    input  wire                  rst_ip,

    input  wire                  wr_i,
    input  wire [SAMPLE_W-1:0]   wr_data_i,
    input  wire                  wr_lr_i,
    output logic                 credit_o,

    input  wire                  pop_i,
    output logic                 head_valid_o,
    output logic [SAMPLE_W-1:0]  head_data_o,
    output logic                 head_lr_o
);

    // lr flag stored alongside each sample
    logic [SAMPLE_W:0] mem [BUF_DEPTH];

    logic [BUF_AW-1:0] wr_ptr;
    logic [BUF_AW-1:0] rd_ptr;
    logic [BUF_AW:0]   count;

    logic              wr_ok;
    logic              pop_ok;
    logic [BUF_AW-1:0] rd_ptr_nxt;
    logic [BUF_AW:0]   count_nxt;

    assign wr_ok = wr_i && (count != (BUF_AW + 1)'(BUF_DEPTH));
    assign pop_ok = pop_i && head_valid_o;

    assign rd_ptr_nxt = rd_ptr + BUF_AW'(pop_ok);
    assign count_nxt = count + (BUF_AW + 1)'(wr_ok) - (BUF_AW + 1)'(pop_ok);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            head_valid_o <= 1'b0;
            credit_o     <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr       <= rd_ptr_nxt;
            count        <= count_nxt;
            head_valid_o <= (count_nxt != '0);
            // one credit back per consumed sample
            credit_o     <= pop_ok;
        end
    end

    always_ff @(posedge clk491520) begin
        if (wr_ok) begin
            mem[wr_ptr] <= {wr_lr_i, wr_data_i};
        end
        // bypass when the new head is the word being written
        if (wr_ok && (wr_ptr == rd_ptr_nxt)) begin
            head_lr_o   <= wr_lr_i;
            head_data_o <= wr_data_i;
        end else begin
            {head_lr_o, head_data_o} <= mem[rd_ptr_nxt];
        end
    end

endmodule

`default_nettype wire

/* hw/channel_mixer.sv */
// two-input saturating channel mixer
`timescale 1ns/1ns
`default_nettype none

module channel_mixer
    import dmix_pkg::*;
(
    input  wire                  clk491520,
    input  wire                  rst_ip,

    input  wire                  req_i,
    input  wire                  req_lr_i,

    input  wire                  a_valid_i,
    input  wire [SAMPLE_W-1:0]   a_data_i,
    input  wire                  a_lr_i,
    output logic                 a_pop_o,

    input  wire                  b_valid_i,
    input  wire [SAMPLE_W-1:0]   b_data_i,
    input  wire                  b_lr_i,
    output logic                 b_pop_o,

    output logic                 mix_valid_o,
    output logic [SAMPLE_W-1:0]  mix_data_o
);

    localparam logic [SAMPLE_W-1:0] SAT_MAX = {1'b0, {(SAMPLE_W - 1){1'b1}}};
    localparam logic [SAMPLE_W-1:0] SAT_MIN = {1'b1, {(SAMPLE_W - 1){1'b0}}};

    logic                       a_match;
    logic                       b_match;

    logic                       s1_valid;
    logic signed [SAMPLE_W-1:0] s1_a;
    logic signed [SAMPLE_W-1:0] s1_b;

    logic signed [SAMPLE_W:0]   sum_w;
    logic [SAMPLE_W-1:0]        sum_sat;

    // a head only counts when it belongs to the requested channel
    assign a_match = a_valid_i && (a_lr_i == req_lr_i);
    assign b_match = b_valid_i && (b_lr_i == req_lr_i);

    assign a_pop_o = req_i && a_match;
    assign b_pop_o = req_i && b_match;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            s1_valid    <= 1'b0;
            mix_valid_o <= 1'b0;
        end else begin
            s1_valid    <= req_i;
            mix_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk491520) begin
        s1_a <= a_match ? a_data_i : '0;
        s1_b <= b_match ? b_data_i : '0;
    end

    // one guard bit is enough for two operands
    assign sum_w = {s1_a[SAMPLE_W-1], s1_a} + {s1_b[SAMPLE_W-1], s1_b};

    always_comb begin
        if (sum_w[SAMPLE_W] == sum_w[SAMPLE_W-1]) begin
            sum_sat = sum_w[SAMPLE_W-1:0];
        end else if (sum_w[SAMPLE_W]) begin
            sum_sat = SAT_MIN;
        end else begin
            sum_sat = SAT_MAX;
        end
    end

    always_ff @(posedge clk491520) begin
        if (s1_valid) begin
            mix_data_o <= sum_sat;
        end
    end

endmodule

`default_nettype wire

/* hw/dac_drv.sv */
// i2s dac serializer
`timescale 1ns/1ns
`default_nettype none

module dac_drv
    import dmix_pkg::*;
(
    input  wire                  clk491520,
    input  wire                  rst_ip,

    output logic                 req_o,
    output logic                 req_lr_o,
    input  wire                  mix_valid_i,
    input  wire [SAMPLE_W-1:0]   mix_data_i,

    output logic                 bck_o,
    output logic                 lrck_o,
    output logic                 dac_data_o
);

    logic [$clog2(BCK_DIV)-1:0]   div_cnt;
    logic [$clog2(SLOT_BITS)-1:0] bit_cnt;
    logic                         lr;

    logic [$clog2(BCK_DIV)-1:0]   div_nxt;
    logic [$clog2(SLOT_BITS)-1:0] bit_nxt;
    logic                         lr_nxt;
    logic                         bit_edge;
    logic                         slot_start;

    logic [SAMPLE_W-1:0]          shreg;

    always_comb begin
        bit_edge   = (div_cnt == BCK_DIV - 1);
        slot_start = bit_edge && (bit_cnt == SLOT_BITS - 1);
        div_nxt    = bit_edge ? '0 : div_cnt + 1'b1;
        if (slot_start) begin
            bit_nxt = '0;
        end else if (bit_edge) begin
            bit_nxt = bit_cnt + 1'b1;
        end else begin
            bit_nxt = bit_cnt;
        end
        lr_nxt = slot_start ? ~lr : lr;
    end

    // counters park at the last right-channel bit so the first tick starts left
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            div_cnt    <= '1;
            bit_cnt    <= '1;
            lr         <= 1'b1;
            req_o      <= 1'b0;
            req_lr_o   <= 1'b0;
            bck_o      <= 1'b0;
            lrck_o     <= 1'b0;
            dac_data_o <= 1'b0;
        end else begin
            div_cnt  <= div_nxt;
            bit_cnt  <= bit_nxt;
            lr       <= lr_nxt;
            req_o    <= slot_start;
            req_lr_o <= lr_nxt;
            // falling bck at the start of every bit period
            bck_o    <= (div_nxt >= BCK_DIV / 2);
            lrck_o   <= lr_nxt;
            if (bit_edge) begin
                dac_data_o <= (bit_nxt != '0) ? shreg[SAMPLE_W-1] : 1'b0;
            end
        end
    end

    // zeros shifted in cover the tail of the slot
    always_ff @(posedge clk491520) begin
        if (mix_valid_i) begin
            shreg <= mix_data_i;
        end else if (bit_edge && (bit_nxt != '0)) begin
            shreg <= {shreg[SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hw/dmix_top.sv */
// audio mixer core top level
`timescale 1ns/1ns
`default_nettype none

module dmix_top
    import dmix_pkg::*;
(
    input  wire                  clk491520,
    input  wire                  rst_ip,

    input  wire                  a_wr_i,
    input  wire [SAMPLE_W-1:0]   a_data_i,
    input  wire                  a_lr_i,
    output logic                 a_credit_o,

    input  wire                  b_wr_i,
    input  wire [SAMPLE_W-1:0]   b_data_i,
    input  wire                  b_lr_i,
    output logic                 b_credit_o,

    output logic                 dac_bck_o,
    output logic                 dac_lrck_o,
    output logic                 dac_data_o
);

    logic                a_head_valid;
    logic [SAMPLE_W-1:0] a_head_data;
    logic                a_head_lr;
    logic                a_pop;

    logic                b_head_valid;
    logic [SAMPLE_W-1:0] b_head_data;
    logic                b_head_lr;
    logic                b_pop;

    logic                req;
    logic                req_lr;
    logic                mix_valid;
    logic [SAMPLE_W-1:0] mix_data;

    sample_buffer buf_a (
        .clk491520    (clk491520),
        .rst_ip       (rst_ip),
        .wr_i         (a_wr_i),
        .wr_data_i    (a_data_i),
        .wr_lr_i      (a_lr_i),
        .credit_o     (a_credit_o),
        .pop_i        (a_pop),
        .head_valid_o (a_head_valid),
        .head_data_o  (a_head_data),
        .head_lr_o    (a_head_lr)
    );

    sample_buffer buf_b (
        .clk491520    (clk491520),
        .rst_ip       (rst_ip),
        .wr_i         (b_wr_i),
        .wr_data_i    (b_data_i),
        .wr_lr_i      (b_lr_i),
        .credit_o     (b_credit_o),
        .pop_i        (b_pop),
        .head_valid_o (b_head_valid),
        .head_data_o  (b_head_data),
        .head_lr_o    (b_head_lr)
    );

    channel_mixer mixer (
        .clk491520   (clk491520),
        .rst_ip      (rst_ip),
        .req_i       (req),
        .req_lr_i    (req_lr),
        .a_valid_i   (a_head_valid),
        .a_data_i    (a_head_data),
        .a_lr_i      (a_head_lr),
        .a_pop_o     (a_pop),
        .b_valid_i   (b_head_valid),
        .b_data_i    (b_head_data),
        .b_lr_i      (b_head_lr),
        .b_pop_o     (b_pop),
        .mix_valid_o (mix_valid),
        .mix_data_o  (mix_data)
    );

    dac_drv dac (
        .clk491520   (clk491520),
        .rst_ip      (rst_ip),
        .req_o       (req),
        .req_lr_o    (req_lr),
        .mix_valid_i (mix_valid),
        .mix_data_i  (mix_data),
        .bck_o       (dac_bck_o),
        .lrck_o      (dac_lrck_o),
        .dac_data_o  (dac_data_o)
    );

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int PERIOD = 40;
    localparam int RST_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // release just after a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_dmix.sv */
// audio mixer testbench
`timescale 1ns/1ns
`default_nettype none

module tb_dmix
    import dmix_pkg::*;
();

    // one i2s half-frame in clock cycles
    localparam int HALF_FRAME = SLOT_BITS * BCK_DIV;
    localparam int SAT_MAX = (1 << (SAMPLE_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (SAMPLE_W - 1));
    localparam int DEPTH = BUF_DEPTH;

    logic                clk491520;
    logic                rst_ip;
    logic                a_wr;
    logic [SAMPLE_W-1:0] a_data;
    logic                a_lr;
    logic                a_credit;
    logic                b_wr;
    logic [SAMPLE_W-1:0] b_data;
    logic                b_lr;
    logic                b_credit;
    logic                dac_bck;
    logic                dac_lrck;
    logic                dac_data;

    logic [31:0] rng_state = 32'h8a8a_df02;
    int errors = 0;
    int timeouts = 0;
    int a_credits = DEPTH;
    int b_credits = DEPTH;
    int a_pulses = 0;
    int b_pulses = 0;
    int a_sent = 0;
    int b_sent = 0;

    // captured words with lrck in the top bit
    logic [SAMPLE_W:0]   words_q[$];
    logic [SAMPLE_W-1:0] cap_word;
    logic                cap_lr = 1'b1;
    int                  cap_idx = 0;

    clk_gen clocks (
        .clk_o (clk491520),
        .rst_o (rst_ip)
    );

    dmix_top DUT (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .a_wr_i     (a_wr),
        .a_data_i   (a_data),
        .a_lr_i     (a_lr),
        .a_credit_o (a_credit),
        .b_wr_i     (b_wr),
        .b_data_i   (b_data),
        .b_lr_i     (b_lr),
        .b_credit_o (b_credit),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data)
    );

    // credit pulses are stable at the falling clock edge
    always @(negedge clk491520) begin
        if (a_credit === 1'b1) begin
            a_credits++;
            a_pulses++;
        end
        if (b_credit === 1'b1) begin
            b_credits++;
            b_pulses++;
        end
        if (a_credits > DEPTH || b_credits > DEPTH) begin
            $display("Fail %0t: more credits returned than samples written", $time);
            errors++;
        end
    end

    // receiver samples data on bit clocks 1 to 24 of each half-frame
    always @(posedge dac_bck) begin
        cap_idx = (dac_lrck != cap_lr) ? 0 : cap_idx + 1;
        cap_lr = dac_lrck;
        if (cap_idx >= 1 && cap_idx <= SAMPLE_W) begin
            cap_word = {cap_word[SAMPLE_W-2:0], dac_data};
        end
        if (cap_idx == SAMPLE_W) begin
            words_q.push_back({dac_lrck, cap_word});
        end
    end

    // upper lcg bits with zero replaced by one
    function automatic logic [SAMPLE_W-1:0] lcg_sample(input logic narrow);
        logic [SAMPLE_W-1:0] s;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        s = narrow ? SAMPLE_W'(rng_state[31:11]) : rng_state[31:8];
        return (s == '0) ? SAMPLE_W'(1) : s;
    endfunction

    function automatic logic [SAMPLE_W-1:0] clamp_sum(input logic [SAMPLE_W-1:0] x,
                                                      input logic [SAMPLE_W-1:0] y);
        int s;
        s = int'($signed(x)) + int'($signed(y));
        if (s > SAT_MAX) begin
            s = SAT_MAX;
        end else if (s < SAT_MIN) begin
            s = SAT_MIN;
        end
        return s[SAMPLE_W-1:0];
    endfunction

    task automatic check_idle(input string when_s);
        if ({dac_bck, dac_lrck, dac_data, a_credit, b_credit} !== 5'b00000) begin
            $display("Fail %0t: outputs not low %s", $time, when_s);
            errors++;
        end
    endtask

    task automatic wait_lrck(input logic level);
        int waited;
        waited = 0;
        while (dac_lrck !== level && waited < 2 * HALF_FRAME) begin
            @(posedge clk491520);
            #2;
            waited++;
        end
        if (dac_lrck !== level) begin
            $display("timeout: lrck never reached %b", level);
            timeouts++;
        end
    endtask

    // writes both streams under credit control and checks the output words
    task automatic run_stream(input logic [SAMPLE_W:0] a_q[$],
                              input logic [SAMPLE_W:0] b_q[$],
                              input logic [SAMPLE_W:0] e_q[$],
                              input string name);
        int ia;
        int ib;
        int ie;
        int waited;
        int limit;
        logic [SAMPLE_W:0] got;
        ia = 0;
        ib = 0;
        ie = 0;
        waited = 0;
        limit = (e_q.size() + 2 * DEPTH + 4) * HALF_FRAME;
        words_q.delete();
        while ((ia < a_q.size() || ib < b_q.size()) && waited < limit) begin
            @(posedge clk491520);
            #2;
            a_wr = 1'b0;
            b_wr = 1'b0;
            if (ia < a_q.size() && a_credits > 0) begin
                a_wr = 1'b1;
                {a_lr, a_data} = a_q[ia];
                ia++;
                a_credits--;
                a_sent++;
            end
            if (ib < b_q.size() && b_credits > 0) begin
                b_wr = 1'b1;
                {b_lr, b_data} = b_q[ib];
                ib++;
                b_credits--;
                b_sent++;
            end
            waited++;
        end
        @(posedge clk491520);
        #2;
        a_wr = 1'b0;
        b_wr = 1'b0;
        // silence before the first expected word is skipped
        while (ie < e_q.size() && waited < limit) begin
            if (words_q.size() == 0) begin
                @(posedge clk491520);
                waited++;
            end else begin
                got = words_q.pop_front();
                if (ie > 0 || got[SAMPLE_W-1:0] != '0) begin
                    if (got !== e_q[ie]) begin
                        $display("Fail %0t: %s word %0d lr/data %b/%h, expected %b/%h",
                                 $time, name, ie, got[SAMPLE_W], got[SAMPLE_W-1:0],
                                 e_q[ie][SAMPLE_W], e_q[ie][SAMPLE_W-1:0]);
                        errors++;
                    end
                    ie++;
                end
            end
        end
        while ((a_credits != DEPTH || b_credits != DEPTH) && waited < limit) begin
            @(posedge clk491520);
            waited++;
        end
        if (ia < a_q.size() || ib < b_q.size() || ie < e_q.size()
                || a_credits != DEPTH || b_credits != DEPTH) begin
            $display("timeout: %s stalled after %0d of %0d words", name, ie, e_q.size());
            timeouts++;
        end
        if (a_pulses != a_sent || b_pulses != b_sent) begin
            $display("Fail %0t: %s credit pulses %0d/%0d for %0d/%0d writes",
                     $time, name, a_pulses, b_pulses, a_sent, b_sent);
            errors++;
        end
    endtask

    task automatic reset_state();
        int waited;
        waited = 0;
        @(negedge clk491520);
        while (rst_ip && waited < 20) begin
            check_idle("during reset");
            @(negedge clk491520);
            waited++;
        end
        if (rst_ip) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
        @(negedge clk491520);
        check_idle("in the first cycle after reset");
    endtask

    task automatic single_source();
        logic [SAMPLE_W:0] a_q[$];
        logic [SAMPLE_W:0] b_q[$];
        for (int i = 0; i < 6; i++) begin
            a_q.push_back({i[0], lcg_sample(1'b0)});
        end
        // input b stays idle so every slot is input a alone
        run_stream(a_q, b_q, a_q, "single source");
    endtask

    task automatic input_sum();
        logic [SAMPLE_W:0]   a_q[$];
        logic [SAMPLE_W:0]   b_q[$];
        logic [SAMPLE_W:0]   e_q[$];
        logic [SAMPLE_W-1:0] x;
        logic [SAMPLE_W-1:0] y;
        for (int i = 0; i < 6; i++) begin
            x = lcg_sample(1'b1);
            y = lcg_sample(1'b1);
            a_q.push_back({i[0], x});
            b_q.push_back({i[0], y});
            e_q.push_back({i[0], x + y});
        end
        run_stream(a_q, b_q, e_q, "sum of inputs");
    endtask

    task automatic saturation_limits();
        logic [SAMPLE_W-1:0] xs[4] = '{24'h7ffff0, 24'h800010, 24'h600000, 24'ha00000};
        logic [SAMPLE_W-1:0] ys[4] = '{24'h000100, 24'hffff00, 24'h400000, 24'hc00000};
        logic [SAMPLE_W-1:0] lim[4] = '{24'h7fffff, 24'h800000, 24'h7fffff, 24'h800000};
        logic [SAMPLE_W:0]   a_q[$];
        logic [SAMPLE_W:0]   b_q[$];
        logic [SAMPLE_W:0]   e_q[$];
        for (int i = 0; i < 4; i++) begin
            a_q.push_back({i[0], xs[i]});
            b_q.push_back({i[0], ys[i]});
            e_q.push_back({i[0], lim[i]});
        end
        run_stream(a_q, b_q, e_q, "saturation");
    endtask

    task automatic credit_flow();
        logic [SAMPLE_W:0]   a_q[$];
        logic [SAMPLE_W:0]   b_q[$];
        logic [SAMPLE_W:0]   e_q[$];
        logic [SAMPLE_W-1:0] x;
        logic [SAMPLE_W-1:0] y;
        for (int i = 0; i < 40; i++) begin
            x = lcg_sample(1'b0);
            y = lcg_sample(1'b0);
            a_q.push_back({i[0], x});
            b_q.push_back({i[0], y});
            e_q.push_back({i[0], clamp_sum(x, y)});
        end
        run_stream(a_q, b_q, e_q, "credit stream");
    endtask

    task automatic channel_mismatch();
        logic [SAMPLE_W:0]   a_q[$];
        logic [SAMPLE_W:0]   b_q[$];
        logic [SAMPLE_W:0]   e_q[$];
        logic [SAMPLE_W-1:0] x;
        logic [SAMPLE_W-1:0] y;
        x = lcg_sample(1'b1);
        y = lcg_sample(1'b1);
        a_q.push_back({1'b1, x});
        b_q.push_back({1'b0, y});
        e_q.push_back({1'b0, y});
        e_q.push_back({1'b1, x});
        // write early in a right half-frame so a left request comes next
        wait_lrck(1'b0);
        wait_lrck(1'b1);
        run_stream(a_q, b_q, e_q, "channel mismatch");
    endtask

    initial begin
        a_wr = 1'b0;
        a_data = '0;
        a_lr = 1'b0;
        b_wr = 1'b0;
        b_data = '0;
        b_lr = 1'b0;
        reset_state();
        single_source();
        input_sum();
        saturation_limits();
        credit_flow();
        channel_mismatch();
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/dmix_pkg.sv
hw/sample_buffer.sv
hw/channel_mixer.sv
hw/dac_drv.sv
hw/dmix_top.sv
tests/clk_gen.sv
tests/tb_dmix.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mixer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dmix -f flist.f -o tb_dmix
./obj_dir/tb_dmix | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
